// File: src/armDpPkg.sv
/*
 Instruction-set definitions for the ARMv4 data-processing subset.
 Field widths, encodings of condition, function and shift, and the
 decoded instruction that travels from the decoder to the execute unit.
*/
`default_nettype none

package armDpPkg;

   typedef logic [31:0] word_t;        // Operands, results, bus data
   typedef logic [3:0]  regAddr_t;
   typedef logic [4:0]  shiftAmount_t;
   typedef logic [7:0]  imm8_t;

   // R15 is the PC in ARMv4, not present here
   localparam regAddr_t REG_NONE = 4'd15;

   // Instr[31:28], 1111 is left undefined
   typedef enum logic [3:0] {
      COND_EQ = 4'b0000,   // Z set
      COND_NE = 4'b0001,
      COND_CS = 4'b0010,   // C set
      COND_CC = 4'b0011,
      COND_MI = 4'b0100,   // N set
      COND_PL = 4'b0101,
      COND_VS = 4'b0110,   // V set
      COND_VC = 4'b0111,
      COND_HI = 4'b1000,   // Unsigned higher
      COND_LS = 4'b1001,
      COND_GE = 4'b1010,   // Signed, N == V
      COND_LT = 4'b1011,
      COND_GT = 4'b1100,
      COND_LE = 4'b1101,
      COND_AL = 4'b1110
   } condCode_t;

   // Function field Instr[24:21]
   typedef enum logic [3:0] {
      ALU_AND = 4'b0000,
      ALU_SUB = 4'b0010,
      ALU_ADD = 4'b0100,
      ALU_ORR = 4'b1100
   } aluOp_t;

   // Instr[6:5] for a register operand
   typedef enum logic [1:0] {
      SH_LSL = 2'b00,
      SH_LSR = 2'b01,
      SH_ASR = 2'b10,
      SH_ROR = 2'b11
   } shiftType_t;

   typedef struct packed {
      logic n;
      logic z;
      logic c;
      logic v;
   } flags_t;

   typedef struct packed {
      condCode_t    cond;
      aluOp_t       aluOp;
      logic         immSel;        // Second operand is imm8
      logic         setFlags;      // S bit
      regAddr_t     rn;
      regAddr_t     rd;
      regAddr_t     rm;
      shiftType_t   shiftType;
      shiftAmount_t shiftAmount;
      imm8_t        imm8;
   } decodedInstr_t;

endpackage

`default_nettype wire

// File: src/dpCore.sv
/*
 Top level of the data-processing unit. A host drives it as a Wishbone
 classic slave; each accepted instruction executes in its accepting cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module dpCore (
   input  logic               clk,
   input  logic               reset,
   input  wbPkg::wbRequest_t  bus,
   output wbPkg::wbResponse_t resp
);
   import armDpPkg::*;

   logic          legal;
   logic          issue;
   logic          loadEn;
   regAddr_t      loadAddr;
   word_t         loadData;
   regAddr_t      readAddr;
   word_t         readData;
   decodedInstr_t decoded;
   word_t         rnData;
   word_t         rmData;
   logic          wrEn;
   regAddr_t      wrAddr;
   word_t         wrData;
   flags_t        flags;

   wbSlavePort port0 (
      .clk(clk), .reset(reset), .bus(bus), .resp(resp),
      .legal(legal), .issue(issue),
      .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
      .readAddr(readAddr), .readData(readData), .flags(flags)
   );

   // Decodes the bus word whether or not it is an issue write
   instrDecode decode0 (.instr(bus.dat), .decoded(decoded), .legal(legal));

   registerFile regs0 (
      .clk(clk),
      .rnAddr(decoded.rn), .rmAddr(decoded.rm),
      .rnData(rnData), .rmData(rmData),
      .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
      .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
      .readAddr(readAddr), .readData(readData)
   );

   executeUnit exec0 (
      .clk(clk), .reset(reset), .issue(issue), .decoded(decoded),
      .rnData(rnData), .rmData(rmData),
      .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData), .flags(flags)
   );

endmodule

`default_nettype wire

// File: src/executeUnit.sv
/*
 Execute stage of the unit: constant barrel shifter, ALU, condition check
 against the stored NZCV and the flags register. An issued instruction
 writes rd and the flags at the accepting clock edge.
*/
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    issue,
   input  armDpPkg::decodedInstr_t decoded,
   input  armDpPkg::word_t         rnData,
   input  armDpPkg::word_t         rmData,
   output logic                    wrEn,
   output armDpPkg::regAddr_t      wrAddr,
   output armDpPkg::word_t         wrData,
   output armDpPkg::flags_t        flags
);
   import armDpPkg::*;

   word_t       shifted;
   logic [63:0] rotWide;
   word_t       srcB;
   word_t       condInvB;
   logic [32:0] sum;
   word_t       result;
   logic        isArith;
   logic        isSub;
   flags_t      aluFlags;
   logic        condPass;

   // Rotate as a right shift of the doubled word
   assign rotWide = {rmData, rmData} >> decoded.shiftAmount;

   always_comb
   begin
      case (decoded.shiftType)
         SH_LSL: shifted = rmData << decoded.shiftAmount;
         SH_LSR: shifted = rmData >> decoded.shiftAmount;
         SH_ASR: shifted = $signed(rmData) >>> decoded.shiftAmount;
         SH_ROR: shifted = rotWide[31:0];
      endcase
   end

   assign srcB = decoded.immSel ? {24'b0, decoded.imm8} : shifted;

   assign isSub    = (decoded.aluOp == ALU_SUB);
   assign isArith  = (decoded.aluOp == ALU_ADD) | isSub;
   assign condInvB = isSub ? ~srcB : srcB;
   assign sum      = {1'b0, rnData} + {1'b0, condInvB} + {32'b0, isSub};

   always_comb
   begin
      case (decoded.aluOp)
         ALU_AND: result = rnData & srcB;
         ALU_ORR: result = rnData | srcB;
         default: result = sum[31:0];
      endcase
   end

   assign aluFlags.n = result[31];
   assign aluFlags.z = (result == 32'b0);
   assign aluFlags.c = sum[32];            // SUB: no borrow
   assign aluFlags.v = ~(rnData[31] ^ srcB[31] ^ isSub) & (rnData[31] ^ sum[31]);

   always_comb
   begin
      case (decoded.cond)
         COND_EQ: condPass = flags.z;
         COND_NE: condPass = ~flags.z;
         COND_CS: condPass = flags.c;
         COND_CC: condPass = ~flags.c;
         COND_MI: condPass = flags.n;
         COND_PL: condPass = ~flags.n;
         COND_VS: condPass = flags.v;
         COND_VC: condPass = ~flags.v;
         COND_HI: condPass = flags.c & ~flags.z;
         COND_LS: condPass = ~flags.c | flags.z;
         COND_GE: condPass = (flags.n == flags.v);
         COND_LT: condPass = (flags.n != flags.v);
         COND_GT: condPass = ~flags.z & (flags.n == flags.v);
         COND_LE: condPass = flags.z | (flags.n != flags.v);
         COND_AL: condPass = 1'b1;
         default: condPass = 1'b0;          // 1111 never issues
      endcase
   end

   assign wrEn   = issue & condPass;
   assign wrAddr = decoded.rd;
   assign wrData = result;

   // Logic ops leave C and V alone
   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
         flags <= '0;
      else if (issue && condPass && decoded.setFlags)
      begin
         flags.n <= aluFlags.n;
         flags.z <= aluFlags.z;
         if (isArith)
         begin
            flags.c <= aluFlags.c;
            flags.v <= aluFlags.v;
         end
      end
   end

endmodule

`default_nettype wire

// File: src/instrDecode.sv
/*
 Combinational decoder for the data-processing subset. Splits the
 instruction word into its fields and flags any encoding outside the subset.
*/
`timescale 1ns/1ps
`default_nettype none

module instrDecode (
   input  armDpPkg::word_t         instr,
   output armDpPkg::decodedInstr_t decoded,
   output logic                    legal
);
   import armDpPkg::*;

   logic condOk;
   logic opOk;
   logic functOk;
   logic shiftOk;
   logic regsOk;

   always_comb
   begin
      decoded.cond        = condCode_t'(instr[31:28]);
      decoded.aluOp       = aluOp_t'(instr[24:21]);
      decoded.immSel      = instr[25];
      decoded.setFlags    = instr[20];
      decoded.rn          = instr[19:16];
      decoded.rd          = instr[15:12];
      decoded.rm          = instr[3:0];
      decoded.shiftType   = shiftType_t'(instr[6:5]);
      decoded.shiftAmount = instr[11:7];
      decoded.imm8        = instr[7:0];     // Zero-extended later
   end

   assign condOk = (instr[31:28] != 4'b1111);
   assign opOk   = (instr[27:26] == 2'b00);

   always_comb
   begin
      case (instr[24:21])
         ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR: functOk = 1'b1;
         default:                            functOk = 1'b0;
      endcase
   end

   // Register-shifted register form is not supported
   assign shiftOk = instr[25] | ~instr[4];

   // Rm only counts for the register form
   assign regsOk = (decoded.rn != REG_NONE) &&
                   (decoded.rd != REG_NONE) &&
                   (instr[25] || (decoded.rm != REG_NONE));

   assign legal = condOk & opOk & functOk & shiftOk & regsOk;

endmodule

`default_nettype wire

// File: src/registerFile.sv
/*
 Fifteen 32-bit registers. Two combinational read ports feed the execute
 unit, a third serves bus readback; writes come from either the execute
 unit or a bus load and take effect at the rising edge.
*/
`timescale 1ns/1ps
`default_nettype none

module registerFile (
   input  logic               clk,
   input  armDpPkg::regAddr_t rnAddr,
   input  armDpPkg::regAddr_t rmAddr,
   output armDpPkg::word_t    rnData,
   output armDpPkg::word_t    rmData,
   input  logic               wrEn,
   input  armDpPkg::regAddr_t wrAddr,
   input  armDpPkg::word_t    wrData,
   input  logic               loadEn,
   input  armDpPkg::regAddr_t loadAddr,
   input  armDpPkg::word_t    loadData,
   input  armDpPkg::regAddr_t readAddr,
   output armDpPkg::word_t    readData
);
   import armDpPkg::*;
   import wbPkg::*;

   word_t regs [REG_COUNT];

   always_ff @(posedge clk)
   begin
      if (wrEn)
         regs[wrAddr] <= wrData;
      else if (loadEn)
         regs[loadAddr] <= loadData;
   end

   assign rnData   = regs[rnAddr];
   assign rmData   = regs[rmAddr];
   assign readData = regs[readAddr];    // Bus readback

   // Issue and load come from exclusive bus transfers
   oneWriter: assert property (@(posedge clk) !(wrEn && loadEn));

endmodule

`default_nettype wire

// File: src/wbPkg.sv
/*
 Wishbone side of the unit: the word address map and the request and
 response bundles exchanged with the host.
*/
`default_nettype none

package wbPkg;

   typedef logic [4:0] wbAddr_t;       // Word address

   // Addresses 0 to 14 map straight onto the registers
   localparam int REG_COUNT = 15;

   // Write issues an instruction, read returns NZCV
   localparam wbAddr_t ISSUE_ADDR = 5'd16;

   // Held by the master until ack or err is seen
   typedef struct packed {
      logic            cyc;
      logic            stb;
      logic            we;
      wbAddr_t         adr;
      armDpPkg::word_t dat;
   } wbRequest_t;

   // Registered, one of ack or err for a single cycle
   typedef struct packed {
      logic            ack;
      logic            err;
      armDpPkg::word_t dat;
   } wbResponse_t;

endpackage

`default_nettype wire

// File: src/wbSlavePort.sv
/*
 Wishbone classic slave for the data-processing unit. Decodes the address
 map, loads and reads registers, issues instructions and answers every
 transfer with a registered ack or err one cycle after it is seen.
*/
`timescale 1ns/1ps
`default_nettype none

module wbSlavePort (
   input  logic                  clk,
   input  logic                  reset,
   input  wbPkg::wbRequest_t     bus,
   output wbPkg::wbResponse_t    resp,
   input  logic                  legal,
   output logic                  issue,
   output logic                  loadEn,
   output armDpPkg::regAddr_t    loadAddr,
   output armDpPkg::word_t       loadData,
   output armDpPkg::regAddr_t    readAddr,
   input  armDpPkg::word_t       readData,
   input  armDpPkg::flags_t      flags
);
   import armDpPkg::*;
   import wbPkg::*;

   logic  newReq;
   logic  isReg;
   logic  isIssue;
   logic  okay;
   logic  ackQ;
   logic  errQ;
   word_t datQ;
   word_t rdMux;

   // A request still high during its answer cycle is not new
   assign newReq  = bus.cyc & bus.stb & ~(ackQ | errQ);

   assign isReg   = (bus.adr < REG_COUNT);
   assign isIssue = (bus.adr == ISSUE_ADDR);

   // Illegal instruction words and unmapped addresses get err
   assign okay = isReg | (isIssue & (~bus.we | legal));

   assign issue    = newReq & bus.we & isIssue & legal;
   assign loadEn   = newReq & bus.we & isReg;
   assign loadAddr = bus.adr[3:0];
   assign loadData = bus.dat;
   assign readAddr = bus.adr[3:0];

   always_comb
   begin
      if (isIssue)
         rdMux = {28'b0, flags};    // NZCV in bits 3..0
      else
         rdMux = readData;
   end

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         ackQ <= 1'b0;
         errQ <= 1'b0;
      end
      else
      begin
         ackQ <= newReq & okay;
         errQ <= newReq & ~okay;
      end
   end

   // Sampled together with the answer
   always_ff @(posedge clk)
   begin
      if (newReq & ~bus.we)
         datQ <= rdMux;
   end

   assign resp.ack = ackQ;
   assign resp.err = errQ;
   assign resp.dat = datQ;

   ackErrExclusive: assert property (
      @(posedge clk) disable iff (reset) !(resp.ack && resp.err));

   // No transfer is answered twice
   singleCycleAnswer: assert property (
      @(posedge clk) disable iff (reset)
      (resp.ack || resp.err) |=> !(resp.ack || resp.err));

endmodule

`default_nettype wire

// File: testbench/dpModel.svh
/*
 Reference model of the data-processing subset for the testbench.
 Included inside the testbench module after its package imports; works on
 the module's copies of the registers and flags.
*/
`ifndef DP_MODEL_SVH
`define DP_MODEL_SVH

typedef struct packed {
   word_t  result;
   flags_t flags;
} aluOut_t;

// Instruction word from its fields
function automatic word_t encodeInstr(condCode_t cond, aluOp_t op, logic immSel, logic s,
                                      regAddr_t rn, regAddr_t rd, logic [11:0] op2);
   return {cond, 2'b00, immSel, op, s, rn, rd, op2};
endfunction

// Zero amount passes the value through for every kind
function automatic word_t shiftModel(word_t val, shiftType_t kind, shiftAmount_t amt);
   word_t r;
   r = val;
   if (amt != 0)
   begin
      case (kind)
         SH_LSL:  r = val << amt;
         SH_LSR:  r = val >> amt;
         SH_ASR:  r = $signed(val) >>> amt;
         default: r = (val >> amt) | (val << (32 - int'(amt)));
      endcase
   end
   return r;
endfunction

function automatic aluOut_t aluModel(aluOp_t op, word_t a, word_t b);
   aluOut_t     o;
   logic [32:0] wide;
   o = '0;
   case (op)
      ALU_ADD:
      begin
         wide = {1'b0, a} + {1'b0, b};
         o.result = wide[31:0];
         o.flags.c = wide[32];
         o.flags.v = (a[31] == b[31]) && (o.result[31] != a[31]);
      end
      ALU_SUB:
      begin
         o.result = a - b;
         o.flags.c = (a >= b);                 // Carry set when nothing borrowed
         o.flags.v = (a[31] != b[31]) && (o.result[31] != a[31]);
      end
      ALU_AND: o.result = a & b;
      default: o.result = a | b;
   endcase
   o.flags.n = o.result[31];
   o.flags.z = (o.result == 32'd0);
   return o;
endfunction

function automatic logic condModel(condCode_t c, flags_t f);
   case (c)
      COND_EQ: return f.z;
      COND_NE: return !f.z;
      COND_CS: return f.c;
      COND_CC: return !f.c;
      COND_MI: return f.n;
      COND_PL: return !f.n;
      COND_VS: return f.v;
      COND_VC: return !f.v;
      COND_HI: return f.c && !f.z;
      COND_LS: return !f.c || f.z;
      COND_GE: return f.n == f.v;
      COND_LT: return f.n != f.v;
      COND_GT: return !f.z && (f.n == f.v);
      COND_LE: return f.z || (f.n != f.v);
      COND_AL: return 1'b1;
      default: return 1'b0;
   endcase
endfunction

function automatic logic legalModel(word_t instr);
   logic ok;
   ok = 1'b1;
   if (instr[31:28] == 4'b1111)
      ok = 1'b0;
   if (instr[27:26] != 2'b00)
      ok = 1'b0;
   case (instr[24:21])
      4'b0000, 4'b0010, 4'b0100, 4'b1100: ;
      default: ok = 1'b0;
   endcase
   if (!instr[25] && instr[4])
      ok = 1'b0;                                // Register-shifted register
   if (instr[19:16] == 4'd15 || instr[15:12] == 4'd15)
      ok = 1'b0;
   if (!instr[25] && instr[3:0] == 4'd15)
      ok = 1'b0;
   return ok;
endfunction

// Executes one legal instruction on the model state
function automatic void applyModel(word_t instr);
   word_t   opB;
   aluOut_t o;
   aluOp_t  op;
   op = aluOp_t'(instr[24:21]);
   if (instr[25])
      opB = {24'b0, instr[7:0]};
   else
      opB = shiftModel(regModel[instr[3:0]], shiftType_t'(instr[6:5]), instr[11:7]);
   o = aluModel(op, regModel[instr[19:16]], opB);
   if (condModel(condCode_t'(instr[31:28]), flagModel))
   begin
      regModel[instr[15:12]] = o.result;
      if (instr[20])
      begin
         flagModel.n = o.flags.n;
         flagModel.z = o.flags.z;
         if (op == ALU_ADD || op == ALU_SUB)   // Logic ops keep C and V
         begin
            flagModel.c = o.flags.c;
            flagModel.v = o.flags.v;
         end
      end
   end
endfunction

`endif

// File: testbench/dpCoreTb.sv
/*
 Testbench for dpCore. Loads and reads registers over Wishbone, issues
 random legal, conditional and illegal instructions and compares every
 answer with the reference model in dpModel.svh.
*/
`timescale 1ns/1ps
`default_nettype none

module dpCoreTb;
   import armDpPkg::*;
   import wbPkg::*;

   localparam int N_LEGAL     = 400;
   localparam int N_COND      = 150;
   localparam int N_ILLEGAL   = 100;
   localparam int N_TRANSFERS = 31 + 3 * N_LEGAL + 6 * N_COND + 3 * N_ILLEGAL + 15 + 32 + 15;
   localparam int TIMEOUT     = 4 * N_TRANSFERS + 100;

   logic        clk = 1'b0;
   logic        reset;
   wbRequest_t  bus;
   wbResponse_t resp;
   word_t       regModel [REG_COUNT];
   flags_t      flagModel;
   int          cycleCount = 0;

   `include "dpModel.svh"

   dpCore dut0 (.clk(clk), .reset(reset), .bus(bus), .resp(resp));

   always #20 clk = ~clk;

   always @(posedge clk)
   begin
      cycleCount++;
      if (cycleCount > TIMEOUT)
      begin
         $display("Run exceeded %0d cycles without finishing", TIMEOUT);
         failRun();
      end
   end

   always @(negedge clk)
   begin
      if (!reset && resp.ack && resp.err)
      begin
         $display("ack and err were high in the same cycle");
         failRun();
      end
   end

   task automatic failRun();
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at first failure");
   endtask

   task automatic checkWord(input string name, input word_t expected, input word_t actual);
      if (actual !== expected)
      begin
         $display("error: %s expected %h actual %h", name, expected, actual);
         failRun();
      end
   endtask

   task automatic checkFlags(input string name, input flags_t expected, input flags_t actual);
      if (actual !== expected)
      begin
         $display("error: %s expected NZCV %b actual %b", name, expected, actual);
         failRun();
      end
   endtask

   task automatic checkResponse(input string name, input logic expectErr, input wbResponse_t r);
      if (r.err !== expectErr || r.ack !== !expectErr)
      begin
         $display("error: %s expected %s actual ack=%b err=%b", name,
                  expectErr ? "err" : "ack", r.ack, r.err);
         failRun();
      end
   endtask

   // Starts and ends on a falling edge. The request stays up through the
   // answer cycle, as a master that samples ack at the rising edge keeps it
   task automatic busTransfer(input logic we, input wbAddr_t adr, input word_t dat,
                              output wbResponse_t r);
      bus.cyc = 1'b1;
      bus.stb = 1'b1;
      bus.we  = we;
      bus.adr = adr;
      bus.dat = dat;
      @(negedge clk);
      r = resp;
      if (!(r.ack || r.err))
      begin
         $display("No answer one cycle after a request to address %0d", adr);
         failRun();
      end
      @(negedge clk);
      bus = '0;
      if (resp.ack || resp.err)
      begin
         $display("Request to address %0d was answered a second time", adr);
         failRun();
      end
   endtask

   task automatic checkRegister(input regAddr_t a, input string name);
      wbResponse_t r;
      busTransfer(1'b0, {1'b0, a}, 32'd0, r);
      checkResponse({name, " read"}, 1'b0, r);
      checkWord($sformatf("%s r%0d", name, a), regModel[a], r.dat);
   endtask

   task automatic checkFlagsRead(input string name);
      wbResponse_t r;
      busTransfer(1'b0, ISSUE_ADDR, 32'd0, r);
      checkResponse({name, " flag read"}, 1'b0, r);
      checkFlags({name, " flags"}, flagModel, flags_t'(r.dat[3:0]));
      checkWord({name, " flag upper bits"}, 32'd0, r.dat & 32'hFFFF_FFF0);
   endtask

   task automatic checkAllRegisters(input string name);
      for (int i = 0; i < REG_COUNT; i++)
         checkRegister(regAddr_t'(i), name);
   endtask

   // Issues one word, then reads back rd and the flags
   task automatic issueInstr(input word_t instr, input string name);
      wbResponse_t r;
      logic        expectErr;
      regAddr_t    rdCheck;
      expectErr = !legalModel(instr);
      busTransfer(1'b1, ISSUE_ADDR, instr, r);
      checkResponse({name, " issue"}, expectErr, r);
      if (!expectErr)
         applyModel(instr);
      rdCheck = (instr[15:12] == 4'd15) ? regAddr_t'(0) : instr[15:12];
      checkRegister(rdCheck, name);
      checkFlagsRead(name);
   endtask

   function automatic word_t randomLegal(condCode_t cond, logic forceS);
      aluOp_t      op;
      logic        immSel;
      logic [11:0] op2;
      case ($urandom % 4)
         0: op = ALU_AND;
         1: op = ALU_SUB;
         2: op = ALU_ADD;
         default: op = ALU_ORR;
      endcase
      immSel = 1'($urandom);
      if (immSel)
         op2 = {4'b0, 8'($urandom)};
      else
         op2 = {5'($urandom), 2'($urandom), 1'b0, 4'($urandom % 15)};
      return encodeInstr(cond, op, immSel, forceS | 1'($urandom),
                         4'($urandom % 15), 4'($urandom % 15), op2);
   endfunction

   // Breaks a legal word in one of the five illegal ways
   function automatic word_t corruptInstr(word_t instr, int kind);
      word_t w;
      w = instr;
      case (kind)
         0: w[31:28] = 4'b1111;
         1: w[27:26] = 2'($urandom % 3 + 1);
         2:
         begin
            w[24:21] = 4'($urandom);
            if (w[24:21] inside {4'b0000, 4'b0010, 4'b0100, 4'b1100})
               w[21] = 1'b1;                    // Odd codes are all undefined
         end
         3:
         begin
            w[25] = 1'b0;
            w[4]  = 1'b1;
         end
         default:
         begin
            case ($urandom % 3)
               0: w[19:16] = 4'd15;
               1: w[15:12] = 4'd15;
               default:
               begin
                  w[25]  = 1'b0;
                  w[4]   = 1'b0;
                  w[3:0] = 4'd15;
               end
            endcase
         end
      endcase
      return w;
   endfunction

   initial
   begin
      wbResponse_t r;
      void'($urandom(32'ha877));
      bus       = '0;
      reset     = 1'b1;
      flagModel = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      checkFlagsRead("reset");
      for (int i = 0; i < REG_COUNT; i++)
      begin
         regModel[i] = $urandom;
         busTransfer(1'b1, wbAddr_t'(i), regModel[i], r);
         checkResponse("load", 1'b0, r);
      end
      checkAllRegisters("readback");

      for (int i = 0; i < N_LEGAL; i++)
         issueInstr(randomLegal(COND_AL, 1'b0), $sformatf("legal %0d", i));

      for (int i = 0; i < N_COND; i++)
      begin
         issueInstr(randomLegal(COND_AL, 1'b1), $sformatf("cond setup %0d", i));
         issueInstr(randomLegal(condCode_t'($urandom % 15), 1'b0), $sformatf("cond %0d", i));
      end

      for (int i = 0; i < N_ILLEGAL; i++)
         issueInstr(corruptInstr(randomLegal(COND_AL, 1'b1), i % 5),
                    $sformatf("illegal %0d", i));
      checkAllRegisters("after illegal");

      for (int a = 15; a < 32; a++)
      begin
         if (a != 16)
         begin
            busTransfer(1'b1, a[4:0], $urandom, r);
            checkResponse($sformatf("unmapped write %0d", a), 1'b1, r);
            busTransfer(1'b0, a[4:0], 32'd0, r);
            checkResponse($sformatf("unmapped read %0d", a), 1'b1, r);
         end
      end
      checkAllRegisters("after unmapped");

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+testbench
src/armDpPkg.sv
src/wbPkg.sv
src/wbSlavePort.sv
src/instrDecode.sv
src/registerFile.sv
src/executeUnit.sv
src/dpCore.sv
testbench/dpCoreTb.sv
